// ==== hw/samasic_config.svh ====
`ifndef SAMASIC_CONFIG_SVH
`define SAMASIC_CONFIG_SVH

// Horizontal regions, in pixel clocks
`define HACTIVEREGION 512
`define RBORDER       64
`define HFPORCH       16
`define HSYNC         64
`define HBPORCH       64
`define LBORDER       48
`define HTOTAL        (`HACTIVEREGION + `RBORDER + `HFPORCH + `HSYNC + `HBPORCH + `LBORDER)

// Vertical regions, in scan lines
`define VACTIVEREGION 192
`define BBORDER       48
`define VFPORCH       4
`define VSYNC         4
`define VBPORCH       16
`define TBORDER       48
`define VTOTAL        (`VACTIVEREGION + `BBORDER + `VFPORCH + `VSYNC + `VBPORCH + `TBORDER)

// Sync and retrace interrupt positions
`define BEGINHSYNC    (`HACTIVEREGION + `RBORDER + `HFPORCH)
`define ENDHSYNC      (`BEGINHSYNC + `HSYNC)
`define BEGINVSYNCH   (`HACTIVEREGION + `RBORDER + `HFPORCH + `HSYNC + `HBPORCH)
`define BEGINVINTH    (`HACTIVEREGION + `RBORDER + `HFPORCH)
`define BEGINVINTV    (`VACTIVEREGION + `BBORDER + `VFPORCH - 1)
`define ENDVINTV      (`VACTIVEREGION + `BBORDER + `VFPORCH)
`define ENDVINTH      ((`BEGINVINTH + 256) % `HTOTAL)

// Contention window within a 16 clock character cell
`define CONT_SLOTS      10
`define MODE1_CONT_COLS 40

// I/O ports
`define IOADDR_VMPR     8'd252
`define IOADDR_HMPR     8'd251
`define IOADDR_LMPR     8'd250
`define IOADDR_BORDER   8'd254
`define IOADDR_LINEINT  8'd249
`define IOADDR_BASECLUT 8'd248

`define VMPR_RESET    8'h60
`define LINEINT_RESET 8'hFF

`endif

// ==== hw/samasic_pkg.sv ====
package samasic_pkg;

    typedef logic [15:0] cpu_addr_t;
    typedef logic [7:0]  byte_t;
    // 5 bit page on top of a 14 bit offset
    typedef logic [18:0] ram_addr_t;
    typedef logic [4:0]  page_t;
    typedef logic [9:0]  hcount_t;
    typedef logic [8:0]  vcount_t;

    typedef enum logic [1:0] {
        MODE1 = 2'd0,
        MODE2 = 2'd1,
        MODE3 = 2'd2,
        MODE4 = 2'd3
    } screen_mode_t;

    // CPU pins as seen by the gate array
    typedef struct packed {
        logic      mreq_n;
        logic      iorq_n;
        logic      rd_n;
        logic      wr_n;
        cpu_addr_t addr;
        byte_t     data;
    } cpu_bus_t;

    // Paging fields from LMPR and HMPR
    typedef struct packed {
        page_t low_page;
        page_t high_page;
        logic  rom_in_section_a;
        logic  rom_in_section_d;
        logic  write_protect_section_a;
    } mem_cfg_t;

    typedef struct packed {
        screen_mode_t screen_mode;
        page_t        screen_page;
        logic         screen_off;
    } video_cfg_t;

    typedef struct packed {
        hcount_t hc;
        vcount_t vc;
        logic    display_enable;
    } raster_t;

endpackage

// ==== hw/asic_control.sv ====
`timescale 1ns/1ns
`include "samasic_config.svh"

module asic_control
    import samasic_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  cpu_bus_t   bus,
    input  byte_t      data_from_ram,
    output byte_t      data_to_cpu,
    output mem_cfg_t   mem_cfg,
    output video_cfg_t video_cfg,
    output logic       mic,
    output logic       beep
);

    byte_t vmpr;
    byte_t hmpr;
    byte_t lmpr;
    byte_t border;
    byte_t lineint;
    logic [6:0] clut [16];

    byte_t port;
    logic  io_wr;
    logic  io_rd;

    // Only the low address byte selects the port
    assign port  = bus.addr[7:0];
    assign io_wr = !bus.iorq_n && !bus.wr_n;
    assign io_rd = !bus.iorq_n && !bus.rd_n;

    ////////////////////////////////////////////////////////////
    // Port registers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            vmpr    <= `VMPR_RESET;
            hmpr    <= '0;
            lmpr    <= '0;
            border  <= '0;
            lineint <= `LINEINT_RESET;
        end else if (io_wr) begin
            case (port)
                `IOADDR_VMPR:    vmpr    <= bus.data;
                `IOADDR_HMPR:    hmpr    <= bus.data;
                `IOADDR_LMPR:    lmpr    <= bus.data;
                `IOADDR_BORDER:  border  <= bus.data;
                `IOADDR_LINEINT: lineint <= bus.data;
                default: ;
            endcase
        end
    end

    // CLUT entry comes from the high address nibble, xF8h
    always_ff @(posedge clk) begin
        if (io_wr && port == `IOADDR_BASECLUT) begin
            clut[bus.addr[11:8]] <= bus.data[6:0];
        end
    end

    ////////////////////////////////////////////////////////////
    // CPU read data
    ////////////////////////////////////////////////////////////
    always_comb begin
        if (io_rd) begin
            case (port)
                `IOADDR_LMPR: data_to_cpu = lmpr;
                `IOADDR_HMPR: data_to_cpu = hmpr;
                `IOADDR_VMPR: data_to_cpu = vmpr;
                default:      data_to_cpu = 8'hFF;
            endcase
        end else begin
            data_to_cpu = data_from_ram;
        end
    end

    assign mem_cfg = '{
        low_page:                lmpr[4:0],
        high_page:               hmpr[4:0],
        rom_in_section_a:        lmpr[5],
        rom_in_section_d:        lmpr[6],
        write_protect_section_a: lmpr[7]
    };

    assign video_cfg = '{
        screen_mode: screen_mode_t'(vmpr[6:5]),
        screen_page: vmpr[4:0],
        screen_off:  border[7]
    };

    // Audio lines straight off the border port
    assign mic  = border[3];
    assign beep = border[4];

endmodule

// ==== hw/raster_timing.sv ====
`timescale 1ns/1ns
`include "samasic_config.svh"

module raster_timing
    import samasic_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    screen_off,
    output raster_t raster,
    output logic    csync,
    output logic    int_n
);

    hcount_t hc;
    vcount_t vc;
    logic    hc_last;
    logic    vc_last;
    logic    hsync_win;
    logic    vsync_win;
    logic    display_enable;

    assign hc_last = (hc == hcount_t'(`HTOTAL - 1));
    assign vc_last = (vc == vcount_t'(`VTOTAL - 1));

    ////////////////////////////////////////////////////////////
    // Pixel and scan line counters
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            hc <= '0;
            vc <= '0;
        end else if (hc_last) begin
            hc <= '0;
            vc <= vc_last ? '0 : vc + 9'd1;
        end else begin
            hc <= hc + 10'd1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Composite sync and retrace interrupt
    ////////////////////////////////////////////////////////////
    always_comb begin
        hsync_win = (hc >= hcount_t'(`BEGINHSYNC)) && (hc < hcount_t'(`ENDHSYNC));
        // Vertical sync starts and ends mid line
        vsync_win = (vc > vcount_t'(`BEGINVINTV) && vc < vcount_t'(`BEGINVINTV + `VSYNC))
                 || (vc == vcount_t'(`BEGINVINTV) && hc >= hcount_t'(`BEGINVSYNCH))
                 || (vc == vcount_t'(`BEGINVINTV + `VSYNC) && hc < hcount_t'(`BEGINVSYNCH));
        csync = ~(hsync_win ^ vsync_win);
        int_n = ~((vc == vcount_t'(`BEGINVINTV) && hc >= hcount_t'(`BEGINVINTH))
               || (vc == vcount_t'(`ENDVINTV) && hc < hcount_t'(`ENDVINTH)));
    end

    // Pixels fetched only inside the active area
    assign display_enable = (vc < vcount_t'(`VACTIVEREGION))
                         && (hc < hcount_t'(`HACTIVEREGION))
                         && !screen_off;

    assign raster = '{hc: hc, vc: vc, display_enable: display_enable};

endmodule

// ==== hw/contention_wait.sv ====
`timescale 1ns/1ns
`include "samasic_config.svh"

module contention_wait
    import samasic_pkg::*;
(
    input  cpu_bus_t     bus,
    input  raster_t      raster,
    input  mem_cfg_t     mem_cfg,
    input  screen_mode_t screen_mode,
    output logic         wait_n
);

    logic [3:0] cell_pos;
    logic [5:0] cell_col;
    logic       contention;
    logic       rom_access;
    logic       cpu_cycle;

    assign cell_pos = raster.hc[3:0];
    assign cell_col = raster.hc[9:4];

    ////////////////////////////////////////////////////////////
    // Contention window
    ////////////////////////////////////////////////////////////
    always_comb begin
        if (raster.display_enable) begin
            contention = (cell_pos < 4'(`CONT_SLOTS));
        end else begin
            // Border still steals two slot pairs per cell
            contention = (cell_pos inside {4'd0, 4'd1, 4'd8, 4'd9});
        end
        if (screen_mode == MODE1 && cell_pos < 4'(`CONT_SLOTS)
            && cell_col < 6'(`MODE1_CONT_COLS)) begin
            contention = 1'b1;
        end
    end

    // ROM never shares the bus with video
    assign rom_access = (bus.addr[15:14] == 2'b00 && mem_cfg.rom_in_section_a)
                     || (bus.addr[15:14] == 2'b11 && mem_cfg.rom_in_section_d);

    assign cpu_cycle = !bus.mreq_n || (!bus.iorq_n && (!bus.rd_n || !bus.wr_n));

    assign wait_n = ~(contention && cpu_cycle && !rom_access);

endmodule

// ==== hw/vram_fetch.sv ====
`timescale 1ns/1ns
`include "samasic_config.svh"

module vram_fetch
    import samasic_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  raster_t    raster,
    input  video_cfg_t video_cfg,
    output ram_addr_t  vram_addr,
    output logic       fetch_slot
);

    logic [14:0] screen_offs;
    logic [4:0]  screen_column;
    logic [3:0]  cell_pos;
    logic        frame_end;
    logic        linear_mode;
    page_t       page;
    vcount_t     vc;

    assign cell_pos    = raster.hc[3:0];
    assign vc          = raster.vc;
    assign page        = video_cfg.screen_page;
    assign frame_end   = (raster.vc == vcount_t'(`VTOTAL - 1))
                      && (raster.hc == hcount_t'(`HTOTAL - 1));
    assign linear_mode = (video_cfg.screen_mode == MODE3) || (video_cfg.screen_mode == MODE4);

    // First half of every active cell belongs to video
    assign fetch_slot = raster.display_enable && !cell_pos[3];

    ////////////////////////////////////////////////////////////
    // Screen offset and column counters
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst || frame_end) begin
            screen_offs   <= '0;
            screen_column <= '0;
        end else if (fetch_slot && cell_pos[0]) begin
            if (cell_pos[2:1] == 2'b11) begin
                // Last byte of the cell
                screen_offs   <= screen_offs + 15'd1;
                screen_column <= screen_column + 5'd1;
            end else if (linear_mode) begin
                screen_offs <= screen_offs + 15'd1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Fetch address per screen mode
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (video_cfg.screen_mode)
            MODE1: begin
                // Spectrum layout, attributes at 6K
                if (cell_pos[2]) begin
                    vram_addr = {page, 4'b0110, vc[7:3], screen_column};
                end else begin
                    vram_addr = {page, 1'b0, vc[7:6], vc[2:0], vc[5:3], screen_column};
                end
            end
            // Bitmap plane then attribute plane 8K above
            MODE2:   vram_addr = {page, cell_pos[2], screen_offs[12:0]};
            // 24K linear screen spans an even/odd page pair
            default: vram_addr = {page[4:1], screen_offs};
        endcase
    end

endmodule

// ==== hw/mem_mapper.sv ====
`timescale 1ns/1ns

module mem_mapper
    import samasic_pkg::*;
(
    input  cpu_bus_t  bus,
    input  mem_cfg_t  mem_cfg,
    input  ram_addr_t vram_addr,
    input  logic      fetch_slot,
    output ram_addr_t ramaddr,
    output byte_t     data_to_ram,
    output logic      ramwr,
    output logic      romcs_n
);

    logic [1:0] section;
    page_t      page;
    ram_addr_t  cpu_ramaddr;
    logic       rom_section;
    logic       protected_a;

    assign section = bus.addr[15:14];

    ////////////////////////////////////////////////////////////
    // Section to page mapping
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (section)
            2'b00:   page = mem_cfg.low_page;
            2'b01:   page = mem_cfg.low_page + 5'd1;
            2'b10:   page = mem_cfg.high_page;
            default: page = mem_cfg.high_page + 5'd1;
        endcase
    end

    assign cpu_ramaddr = {page, bus.addr[13:0]};

    assign rom_section = (section == 2'b00 && mem_cfg.rom_in_section_a)
                      || (section == 2'b11 && mem_cfg.rom_in_section_d);
    assign protected_a = (section == 2'b00) && mem_cfg.write_protect_section_a;

    assign romcs_n = ~(!bus.mreq_n && rom_section);

    // Video owns the bus during fetch slots
    assign ramaddr = fetch_slot ? vram_addr : cpu_ramaddr;

    assign ramwr = !bus.mreq_n && !bus.wr_n && !rom_section && !protected_a && !fetch_slot;

    assign data_to_ram = bus.data;

endmodule

// ==== hw/samasic_top.sv ====
`timescale 1ns/1ns

module samasic_top
    import samasic_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      mreq_n,
    input  logic      iorq_n,
    input  logic      rd_n,
    input  logic      wr_n,
    input  cpu_addr_t cpuaddr,
    input  byte_t     data_from_cpu,
    output byte_t     data_to_cpu,
    output logic      wait_n,
    output ram_addr_t ramaddr,
    input  byte_t     data_from_ram,
    output byte_t     data_to_ram,
    output logic      ramwr,
    output logic      romcs_n,
    output logic      mic,
    output logic      beep,
    output logic      csync,
    output logic      int_n
);

    cpu_bus_t   bus;
    mem_cfg_t   mem_cfg;
    video_cfg_t video_cfg;
    raster_t    raster;
    ram_addr_t  vram_addr;
    logic       fetch_slot;

    assign bus = '{
        mreq_n: mreq_n,
        iorq_n: iorq_n,
        rd_n:   rd_n,
        wr_n:   wr_n,
        addr:   cpuaddr,
        data:   data_from_cpu
    };

    ////////////////////////////////////////////////////////////
    // Registers and timing
    ////////////////////////////////////////////////////////////
    asic_control u_control (
        .clk           (clk),
        .rst           (rst),
        .bus           (bus),
        .data_from_ram (data_from_ram),
        .data_to_cpu   (data_to_cpu),
        .mem_cfg       (mem_cfg),
        .video_cfg     (video_cfg),
        .mic           (mic),
        .beep          (beep)
    );

    raster_timing u_raster (
        .clk        (clk),
        .rst        (rst),
        .screen_off (video_cfg.screen_off),
        .raster     (raster),
        .csync      (csync),
        .int_n      (int_n)
    );

    contention_wait u_wait (
        .bus         (bus),
        .raster      (raster),
        .mem_cfg     (mem_cfg),
        .screen_mode (video_cfg.screen_mode),
        .wait_n      (wait_n)
    );

    ////////////////////////////////////////////////////////////
    // RAM side
    ////////////////////////////////////////////////////////////
    vram_fetch u_fetch (
        .clk        (clk),
        .rst        (rst),
        .raster     (raster),
        .video_cfg  (video_cfg),
        .vram_addr  (vram_addr),
        .fetch_slot (fetch_slot)
    );

    mem_mapper u_mapper (
        .bus         (bus),
        .mem_cfg     (mem_cfg),
        .vram_addr   (vram_addr),
        .fetch_slot  (fetch_slot),
        .ramaddr     (ramaddr),
        .data_to_ram (data_to_ram),
        .ramwr       (ramwr),
        .romcs_n     (romcs_n)
    );

endmodule

// ==== tests/samasic_tb.sv ====
`timescale 1ns/1ns
`include "samasic_config.svh"

module samasic_tb
    import samasic_pkg::*;
;

    localparam int     BUS_CYCLES_MAX = 1200;
    localparam longint WATCHDOG_NS =
        (longint'(2 * `HTOTAL * `VTOTAL) + 16 + BUS_CYCLES_MAX * 48) * 4;

    logic      clk;
    logic      rst;
    logic      mreq_n;
    logic      iorq_n;
    logic      rd_n;
    logic      wr_n;
    cpu_addr_t cpuaddr;
    byte_t     data_from_cpu;
    byte_t     data_to_cpu;
    logic      wait_n;
    ram_addr_t ramaddr;
    byte_t     data_from_ram;
    byte_t     data_to_ram;
    logic      ramwr;
    logic      romcs_n;
    logic      mic;
    logic      beep;
    logic      csync;
    logic      int_n;

    // Model state of the gate array
    hcount_t     m_hc;
    vcount_t     m_vc;
    byte_t       lmpr_m = 8'h00;
    byte_t       hmpr_m = 8'h00;
    byte_t       vmpr_m = `VMPR_RESET;
    byte_t       border_m = 8'h00;
    logic [31:0] rng_state = 32'h9866;
    logic        check_fetch = 1'b0;
    logic        prev_int_n = 1'b1;
    int          int_pulses = 0;
    int          int_low_cycles = 0;
    int          error_count = 0;

    samasic_top UUT (
        .clk           (clk),
        .rst           (rst),
        .mreq_n        (mreq_n),
        .iorq_n        (iorq_n),
        .rd_n          (rd_n),
        .wr_n          (wr_n),
        .cpuaddr       (cpuaddr),
        .data_from_cpu (data_from_cpu),
        .data_to_cpu   (data_to_cpu),
        .wait_n        (wait_n),
        .ramaddr       (ramaddr),
        .data_from_ram (data_from_ram),
        .data_to_ram   (data_to_ram),
        .ramwr         (ramwr),
        .romcs_n       (romcs_n),
        .mic           (mic),
        .beep          (beep),
        .csync         (csync),
        .int_n         (int_n)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////
    // Reference functions
    //////////////////////////////////////////////////////////////
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // RAM contents, a hash of the whole address
    function automatic logic [7:0] ram_pattern(input logic [18:0] a);
        logic [31:0] h;
        h = xorshift32(32'h9866 ^ {13'd0, a});
        return h[7:0] ^ h[15:8] ^ h[23:16] ^ h[31:24];
    endfunction

    function automatic logic [18:0] map_ref(input logic [15:0] a, input logic [7:0] lm,
                                            input logic [7:0] hm);
        logic [4:0] pg;
        case (a[15:14])
            2'b00:   pg = lm[4:0];
            2'b01:   pg = lm[4:0] + 5'd1;
            2'b10:   pg = hm[4:0];
            default: pg = hm[4:0] + 5'd1;
        endcase
        return {pg, a[13:0]};
    endfunction

    function automatic logic rom_ref(input logic [15:0] a, input logic [7:0] lm);
        return (a[15:14] == 2'b00 && lm[5]) || (a[15:14] == 2'b11 && lm[6]);
    endfunction

    function automatic logic contention_ref(input int h, input logic de, input logic [1:0] mode);
        int  pos;
        logic c;
        pos = h % 16;
        c = de ? (pos < 10) : (pos == 0 || pos == 1 || pos == 8 || pos == 9);
        if (mode == 2'd0 && pos < 10 && (h / 16) < 40) begin
            c = 1'b1;
        end
        return c;
    endfunction

    // Sync from line 243 at 720 to line 247 at 720
    function automatic logic csync_ref(input int h, input int v);
        logic hs;
        logic vs;
        hs = (h >= 592) && (h < 656);
        vs = (v > 243 && v < 247) || (v == 243 && h >= 720) || (v == 247 && h < 720);
        return !(hs ^ vs);
    endfunction

    function automatic logic int_n_ref(input int h, input int v);
        return !((v == 243 && h >= 592) || (v == 244 && h < 80));
    endfunction

    assign data_from_ram = ram_pattern(ramaddr);

    task automatic report_mismatch(input string what);
        error_count++;
        $display("error at %0t ns: %s", $time, what);
        $display("sim failed");
        $fatal(1, "mismatch");
    endtask

    //////////////////////////////////////////////////////////////
    // Raster model and compare process
    //////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        if (rst) begin
            m_hc <= '0;
            m_vc <= '0;
        end else if (m_hc == 10'd767) begin
            m_hc <= '0;
            m_vc <= (m_vc == 9'd311) ? 9'd0 : m_vc + 9'd1;
        end else begin
            m_hc <= m_hc + 10'd1;
        end
    end

    task automatic check_cycle();
        logic        de;
        logic        fetch;
        logic        rom;
        logic        cycle;
        logic        exp_wait;
        logic        exp_wr;
        logic [7:0]  exp_rd;
        logic [18:0] exp_addr;
        de = (m_vc < 9'd192) && (m_hc < 10'd512) && !border_m[7];
        fetch = de && !m_hc[3];
        rom = rom_ref(cpuaddr, lmpr_m);
        cycle = !mreq_n || (!iorq_n && (!rd_n || !wr_n));
        assert (csync == csync_ref(int'(m_hc), int'(m_vc)))
            else report_mismatch($sformatf("csync %b at hc %0d vc %0d", csync, m_hc, m_vc));
        assert (int_n == int_n_ref(int'(m_hc), int'(m_vc)))
            else report_mismatch($sformatf("int_n %b at hc %0d vc %0d", int_n, m_hc, m_vc));
        assert (mic == border_m[3] && beep == border_m[4])
            else report_mismatch("mic or beep differs from border bits");
        exp_wait = !(contention_ref(int'(m_hc), de, vmpr_m[6:5]) && cycle && !rom);
        assert (wait_n == exp_wait)
            else report_mismatch($sformatf("wait_n %b expected %b at hc %0d", wait_n,
                                           exp_wait, m_hc));
        if (!iorq_n && !rd_n) begin
            case (cpuaddr[7:0])
                8'd250:  exp_rd = lmpr_m;
                8'd251:  exp_rd = hmpr_m;
                8'd252:  exp_rd = vmpr_m;
                default: exp_rd = 8'hFF;
            endcase
        end else begin
            exp_rd = ram_pattern(ramaddr);
        end
        assert (data_to_cpu == exp_rd)
            else report_mismatch($sformatf("data_to_cpu %h expected %h", data_to_cpu, exp_rd));
        if (!mreq_n) begin
            exp_addr = map_ref(cpuaddr, lmpr_m, hmpr_m);
            exp_wr = !wr_n && !rom && !(cpuaddr[15:14] == 2'b00 && lmpr_m[7]) && !fetch;
            assert (romcs_n == !rom) else report_mismatch("romcs_n wrong");
            assert (ramwr == exp_wr)
                else report_mismatch($sformatf("ramwr %b expected %b", ramwr, exp_wr));
            assert (data_to_ram == data_from_cpu) else report_mismatch("data_to_ram wrong");
            if (!fetch) begin
                assert (ramaddr == exp_addr)
                    else report_mismatch($sformatf("ramaddr %h expected %h", ramaddr, exp_addr));
            end
        end else begin
            assert (romcs_n && !ramwr)
                else report_mismatch("romcs_n or ramwr active without a memory cycle");
        end
        // Linear screen, four bytes per cell on the first line
        if (check_fetch && m_vc == 9'd0 && fetch && !m_hc[0] && vmpr_m[6:5] == 2'b11) begin
            exp_addr = {vmpr_m[4:1], 7'd0, m_hc[9:4], m_hc[2:1]};
            assert (ramaddr == exp_addr)
                else report_mismatch($sformatf("fetch ramaddr %h expected %h", ramaddr, exp_addr));
        end
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            check_cycle();
            if (int_n == 1'b0) begin
                int_low_cycles++;
            end
            if (prev_int_n && !int_n) begin
                int_pulses++;
            end
            prev_int_n = int_n;
            // Registers take the value sampled on this edge
            if (!iorq_n && !wr_n) begin
                case (cpuaddr[7:0])
                    8'd250:  lmpr_m = data_from_cpu;
                    8'd251:  hmpr_m = data_from_cpu;
                    8'd252:  vmpr_m = data_from_cpu;
                    8'd254:  border_m = data_from_cpu;
                    default: ;
                endcase
            end
        end
    end

    //////////////////////////////////////////////////////////////
    // CPU bus driver
    //////////////////////////////////////////////////////////////
    task automatic cpu_cycle(input logic is_io, input logic is_wr, input logic [15:0] addr,
                             input logic [7:0] data);
        int held;
        held = 0;
        @(negedge clk);
        cpuaddr = addr;
        data_from_cpu = data;
        mreq_n = is_io;
        iorq_n = !is_io;
        rd_n = is_wr;
        wr_n = !is_wr;
        @(posedge clk);
        while (wait_n !== 1'b1) begin
            held++;
            if (held > 32) begin
                $display("bus cycle held by wait_n for more than 32 clocks");
                $display("sim failed");
                $fatal(1, "stuck bus cycle");
            end
            @(posedge clk);
        end
        @(negedge clk);
        mreq_n = 1'b1;
        iorq_n = 1'b1;
        rd_n = 1'b1;
        wr_n = 1'b1;
    endtask

    task automatic io_write(input logic [7:0] port, input logic [7:0] data);
        cpu_cycle(1'b1, 1'b1, {8'(next_random() >> 8), port}, data);
    endtask

    task automatic io_read(input logic [7:0] port);
        cpu_cycle(1'b1, 1'b0, {8'h00, port}, 8'h00);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog timeout, the test sequence did not finish in time");
        $display("sim failed");
        $fatal(1, "timeout");
    end

    initial begin
        rst = 1'b1;
        mreq_n = 1'b1;
        iorq_n = 1'b1;
        rd_n = 1'b1;
        wr_n = 1'b1;
        cpuaddr = '0;
        data_from_cpu = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Reset values, then a screen page that shows in the fetch address
        io_read(8'd252);
        io_read(8'd251);
        io_read(8'd250);
        io_write(8'd252, 8'h66);

        // Two idle frames in MODE4 for sync, interrupt and fetch
        check_fetch = 1'b1;
        repeat (2 * `HTOTAL * `VTOTAL) @(posedge clk);
        @(negedge clk);
        check_fetch = 1'b0;
        assert (int_pulses == 2 && int_low_cycles == 512)
            else report_mismatch($sformatf("int_n pulses %0d low cycles %0d", int_pulses,
                                           int_low_cycles));

        // Port readback
        for (int i = 0; i < 8; i++) begin
            io_write(8'd250, 8'(next_random()));
            io_write(8'd251, 8'(next_random()));
            io_write(8'd252, 8'(next_random()));
            io_write(8'd254, 8'(next_random()));
            io_read(8'd250);
            io_read(8'd251);
            io_read(8'd252);
            io_read(8'd254);
            io_read(8'd249);
            io_read(8'(next_random()) & 8'hF0);
        end

        // Paging, ROM select and write protection
        for (int i = 0; i < 200; i++) begin
            if (i % 8 == 0) begin
                io_write(8'd250, 8'(next_random()));
                io_write(8'd251, 8'(next_random()));
            end
            repeat (next_random() % 16) @(negedge clk);
            cpu_cycle(1'b0, 1'(next_random()), 16'(next_random()), 8'(next_random()));
        end

        // Contention in MODE1, MODE2, MODE4 and with the screen off
        for (int m = 0; m < 4; m++) begin
            io_write(8'd252, {1'b0, (m == 0) ? 2'd0 : (m == 1) ? 2'd1 : 2'd3, 5'd2});
            io_write(8'd254, (m == 3) ? 8'h80 : 8'h00);
            for (int i = 0; i < 60; i++) begin
                if (i % 10 == 0) begin
                    io_write(8'd250, 8'(next_random()));
                end
                repeat (next_random() % 16) @(negedge clk);
                if (1'(next_random() >> 1)) begin
                    cpu_cycle(1'b1, 1'(next_random()), {8'(next_random()), 8'h10}, 8'h00);
                end else begin
                    cpu_cycle(1'b0, 1'(next_random()), 16'(next_random()),
                              8'(next_random()));
                end
            end
        end

        repeat (4) @(negedge clk);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== samasic.f ====
+incdir+hw
hw/samasic_pkg.sv
hw/asic_control.sv
hw/raster_timing.sv
hw/contention_wait.sv
hw/vram_fetch.sv
hw/mem_mapper.sv
hw/samasic_top.sv
tests/samasic_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# Build and run the testbench, then decide pass or fail from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module samasic_tb -f samasic.f -o samasic_sim \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/samasic_sim > sim.log 2>&1
cat sim.log

grep -q "sim failed" sim.log && exit 1 || grep -q "sim passed" sim.log || exit 1
exit 0
